// File: tb/program_stim.txt
# kind addr word: P = instruction memory, D = data memory, S = expected store (addr data)
# All values are hex; S lines are listed in store order.
P 0000 5020
P 0002 1227
P 0004 147D
P 0006 1642
P 0008 7610
P 000A 58C1
P 000C 9B3F
P 000E 7A11
P 0010 7812
P 0012 5D6C
P 0014 6E08
P 0016 1FC6
P 0018 7E13
P 001A 0802
P 001C 7214
P 001E 7415
P 0020 1279
P 0022 0402
P 0024 7616
P 0026 7817
P 0028 7C18
P 002A 6409
P 002C 7419
P 002E 0FFF
D 0010 1234
D 0012 BEEF
S 0020 000B
S 0022 FFFC
S 0024 0003
S 0026 1240
S 0028 0007
S 002A 0004
S 0030 000C
S 0032 BEEF

// File: project.f
design/lc3b_isa_pkg.sv
design/lc3b_pipe_pkg.sv
design/instruction_fetch.sv
design/instruction_decode.sv
design/execute_stage.sv
design/memory_stage.sv
design/flow_control.sv
design/cpu_datapath.sv
tb/cpu_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module cpu_datapath_tb \
	--Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "Simulation PASSED"
exit 0

// File: tb/cpu_datapath_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath_tb;

	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int MAX_STORES = 64;

	logic      clk;
	logic      arst_n;
	imem_req_t imem_req;
	imem_rsp_t imem_rsp;
	dmem_req_t dmem_req;
	dmem_rsp_t dmem_rsp;

	lc3b_word    imem [MEM_WORDS];
	lc3b_word    dmem [MEM_WORDS];
	lc3b_word    exp_addr [MAX_STORES];
	lc3b_word    exp_data [MAX_STORES];
	int          num_stores;
	int          stores_seen;
	int          cycle_count;
	int          timeout_limit;
	int          post_reset_cycles;
	logic        first_fetch_seen;
	logic [1:0]  imem_delay;
	logic [1:0]  dmem_delay;
	logic [31:0] imem_lcg;
	logic [31:0] dmem_lcg;

	cpu_datapath #(
		.RESET_PC (16'h0000)
	) u_cpu_datapath (
		.clk      (clk),
		.arst_n   (arst_n),
		.imem_req (imem_req),
		.imem_rsp (imem_rsp),
		.dmem_req (dmem_req),
		.dmem_rsp (dmem_rsp)
	);

	always #50 clk = ~clk;

	// Wait cycles 0 to 3 from the upper LCG bits.
	function automatic logic [1:0] lcg_next(inout logic [31:0] state);
		state = state * 32'd1103515245 + 32'd12345;
		return state[17:16];
	endfunction

	task automatic check_value(input string name, input lc3b_word got, input lc3b_word expected);
		if (got !== expected) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic load_stimulus();
		int    fd;
		int    n;
		string line;
		byte   kind;
		logic [15:0] a;
		logic [15:0] d;
		fd = $fopen("tb/program_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/program_stim.txt");
			$display("tests failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%c %h %h", kind, a, d);
				if (n == 3) begin
					case (kind)
						"P": imem[a[8:1]] = d;
						"D": dmem[a[8:1]] = d;
						"S": begin
							exp_addr[num_stores] = a;
							exp_data[num_stores] = d;
							num_stores++;
						end
						default: ;
					endcase
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!arst_n) begin
			imem_rsp <= '0;
		end else begin
			if (!first_fetch_seen && imem_req.read) begin
				check_value("imem_req.addr", imem_req.addr, 16'h0000);
				first_fetch_seen <= 1'b1;
			end
			if (imem_rsp.resp) begin
				imem_rsp.resp <= 1'b0;            // Fetch taken on this edge.
			end else if (imem_req.read) begin
				if (imem_delay == 2'd0) begin
					imem_rsp.resp  <= 1'b1;
					imem_rsp.rdata <= imem[imem_req.addr[8:1]];
					imem_delay     <= lcg_next(imem_lcg);
				end else begin
					imem_delay <= imem_delay - 2'd1;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (!arst_n || post_reset_cycles < 3) begin
			check_value("dmem_req.read", {15'd0, dmem_req.read}, 16'h0000);
			check_value("dmem_req.write", {15'd0, dmem_req.write}, 16'h0000);
		end
		if (!arst_n) begin
			dmem_rsp <= '0;
		end else if (dmem_rsp.resp) begin
			if (dmem_req.write) begin
				if (stores_seen >= num_stores) begin
					$display("A store arrived after all expected stores were seen");
					$display("tests failed");
					$fatal(1);
				end
				check_value("dmem_req.addr", dmem_req.addr, exp_addr[stores_seen]);
				check_value("dmem_req.wdata", dmem_req.wdata, exp_data[stores_seen]);
				stores_seen <= stores_seen + 1;
			end
			dmem_rsp.resp <= 1'b0;
		end else if (dmem_req.read || dmem_req.write) begin
			if (dmem_delay == 2'd0) begin
				dmem_rsp.resp  <= 1'b1;
				dmem_rsp.rdata <= dmem[dmem_req.addr[8:1]];
				if (dmem_req.write)
					dmem[dmem_req.addr[8:1]] <= dmem_req.wdata;
				dmem_delay <= lcg_next(dmem_lcg);
			end else begin
				dmem_delay <= dmem_delay - 2'd1;
			end
		end
	end

	// Timeout.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (arst_n)
			post_reset_cycles <= post_reset_cycles + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles with %0d of %0d stores seen",
				cycle_count, stores_seen, num_stores);
			$display("tests failed");
			$fatal(1);
		end
	end

	initial begin
		clk               = 1'b0;
		arst_n            = 1'b0;
		imem_rsp          = '0;
		dmem_rsp          = '0;
		num_stores        = 0;
		stores_seen       = 0;
		cycle_count       = 0;
		timeout_limit     = 0;
		post_reset_cycles = 0;
		first_fetch_seen  = 1'b0;
		imem_delay        = 2'd0;
		dmem_delay        = 2'd0;
		imem_lcg          = 32'd95;
		dmem_lcg          = 32'd95;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = 16'hF000 | 16'(i * 3);       // Unused opcode, harmless if fetched.
			dmem[i] = 16'(i * 16'h0101) ^ 16'hA5A5;
		end
		load_stimulus();
		if (num_stores == 0) begin
			$display("The stimulus file holds no expected stores");
			$display("tests failed");
			$fatal(1);
		end
		timeout_limit = 40 * num_stores + 200;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		wait (stores_seen == num_stores);
		@(posedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule : cpu_datapath_tb

`default_nettype wire

// File: design/cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath #(
	parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
) (
	input  logic                     clk,
	input  logic                     arst_n,
	output lc3b_pipe_pkg::imem_req_t imem_req,
	input  lc3b_pipe_pkg::imem_rsp_t imem_rsp,
	output lc3b_pipe_pkg::dmem_req_t dmem_req,
	input  lc3b_pipe_pkg::dmem_rsp_t dmem_rsp
);

	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;

	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	mem_wb_t  mem_wb;
	lc3b_word branch_target;
	logic     branch_taken;
	logic     load_use;
	logic     imem_wait;
	logic     dmem_wait;
	logic     en_if;
	logic     en_id;
	logic     en_ex;
	logic     en_mem;
	logic     bubble_ex;
	logic     squash;

	flow_control u_flow_control (
		.clk          (clk),
		.arst_n       (arst_n),
		.imem_wait    (imem_wait),
		.dmem_wait    (dmem_wait),
		.branch_taken (branch_taken),
		.load_use     (load_use),
		.en_if        (en_if),
		.en_id        (en_id),
		.en_ex        (en_ex),
		.en_mem       (en_mem),
		.bubble_ex    (bubble_ex),
		.squash       (squash)
	);

	instruction_fetch #(
		.RESET_PC (RESET_PC)
	) u_instruction_fetch (
		.clk           (clk),
		.arst_n        (arst_n),
		.en_if         (en_if),
		.squash        (squash),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.imem_rsp      (imem_rsp),
		.imem_req      (imem_req),
		.imem_wait     (imem_wait),
		.if_id         (if_id)
	);

	instruction_decode u_instruction_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.en_id     (en_id),
		.bubble_ex (bubble_ex),
		.squash    (squash),
		.if_id     (if_id),
		.mem_wb    (mem_wb),
		.id_ex     (id_ex),
		.load_use  (load_use)
	);

	execute_stage u_execute_stage (
		.clk           (clk),
		.arst_n        (arst_n),
		.en_ex         (en_ex),
		.squash        (squash),
		.id_ex         (id_ex),
		.mem_wb        (mem_wb),
		.ex_mem        (ex_mem),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	memory_stage u_memory_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.en_mem    (en_mem),
		.ex_mem    (ex_mem),
		.dmem_rsp  (dmem_rsp),
		.dmem_req  (dmem_req),
		.dmem_wait (dmem_wait),
		.mem_wb    (mem_wb)
	);

endmodule : cpu_datapath

`default_nettype wire

// File: design/flow_control.sv
`timescale 1ns/100ps
`default_nettype none

module flow_control (
	input  logic clk,
	input  logic arst_n,
	input  logic imem_wait,
	input  logic dmem_wait,
	input  logic branch_taken,
	input  logic load_use,
	output logic en_if,
	output logic en_id,
	output logic en_ex,
	output logic en_mem,
	output logic bubble_ex,
	output logic squash
);

	logic redirect;
	logic squash_q;

	// Branch leaves EX on this edge.
	assign redirect = branch_taken && !dmem_wait;

	// Data port back-pressure holds every stage.
	assign en_mem = !dmem_wait;
	assign en_ex  = !dmem_wait;

	// Load-use holds IF and ID.
	assign en_id  = !dmem_wait && !load_use;
	assign en_if  = !dmem_wait && !load_use;

	assign bubble_ex = !dmem_wait && load_use;

	// The branch outranks load-use; squash also covers a stale fetch.
	assign squash = redirect || squash_q;

	// Wrong-path fetch in flight when the branch resolved.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			squash_q <= 1'b0;
		else if (redirect && imem_wait)
			squash_q <= 1'b1;
		else if (!imem_wait)
			squash_q <= 1'b0;
	end

endmodule : flow_control

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     en_mem,
	input  lc3b_pipe_pkg::ex_mem_t   ex_mem,
	input  lc3b_pipe_pkg::dmem_rsp_t dmem_rsp,
	output lc3b_pipe_pkg::dmem_req_t dmem_req,
	output logic                     dmem_wait,
	output lc3b_pipe_pkg::mem_wb_t   mem_wb
);

	logic do_read;
	logic do_write;

	assign do_read  = ex_mem.valid && ex_mem.cw.mem_read;
	assign do_write = ex_mem.valid && ex_mem.cw.mem_write;

	// Held stable by the freeze until resp.
	assign dmem_req = '{
		read:  do_read,
		write: do_write,
		addr:  ex_mem.alu_out,
		wdata: ex_mem.store_data
	};

	assign dmem_wait = (do_read || do_write) && !dmem_rsp.resp;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else if (en_mem) begin
			mem_wb.valid  <= ex_mem.valid;
			mem_wb.cw     <= ex_mem.cw;
			mem_wb.result <= do_read ? dmem_rsp.rdata : ex_mem.alu_out;
		end
	end

endmodule : memory_stage

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    en_ex,
	input  logic                    squash,
	input  lc3b_pipe_pkg::id_ex_t   id_ex,
	input  lc3b_pipe_pkg::mem_wb_t  mem_wb,
	output lc3b_pipe_pkg::ex_mem_t  ex_mem,
	output logic                    branch_taken,
	output lc3b_isa_pkg::lc3b_word  branch_target
);

	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;

	lc3b_word op_a;
	lc3b_word op_b_reg;
	lc3b_word op_b;
	lc3b_word imm;
	lc3b_word alu_out;
	lc3b_nzp  nzp;

	// Newest producer wins; a load in MEM has no data yet.
	function automatic lc3b_word forward(input lc3b_reg idx, input lc3b_word reg_val);
		if (ex_mem.valid && ex_mem.cw.reg_write && !ex_mem.cw.mem_read && ex_mem.cw.dest == idx)
			return ex_mem.alu_out;
		if (mem_wb.valid && mem_wb.cw.reg_write && mem_wb.cw.dest == idx)
			return mem_wb.result;
		return reg_val;
	endfunction

	always_comb begin
		op_a     = forward(id_ex.sr1_idx, id_ex.src1);
		op_b_reg = forward(id_ex.sr2_idx, id_ex.src2);
		imm      = (id_ex.cw.mem_read || id_ex.cw.mem_write) ? offset6(id_ex.ir) : imm5(id_ex.ir);
		op_b     = id_ex.cw.use_imm ? imm : op_b_reg;
		case (id_ex.cw.alu_op)
			alu_add: alu_out = op_a + op_b;
			alu_and: alu_out = op_a & op_b;
			alu_not: alu_out = ~op_a;
			default: alu_out = op_b;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Condition codes and branch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			nzp <= '0;
		else if (en_ex && id_ex.valid && id_ex.cw.set_cc)
			nzp <= {alu_out[15], alu_out == '0, !alu_out[15] && alu_out != '0};
	end

	assign branch_taken  = id_ex.valid && id_ex.cw.is_branch && |(id_ex.ir[11:9] & nzp);
	assign branch_target = id_ex.pc + offset9(id_ex.ir);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else if (en_ex) begin
			ex_mem.valid      <= id_ex.valid && !squash;   // Taken branch retires here.
			ex_mem.cw         <= id_ex.cw;
			ex_mem.alu_out    <= alu_out;
			ex_mem.store_data <= op_b_reg;
		end
	end

endmodule : execute_stage

`default_nettype wire

// File: design/instruction_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instruction_decode (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   en_id,
	input  logic                   bubble_ex,
	input  logic                   squash,
	input  lc3b_pipe_pkg::if_id_t  if_id,
	input  lc3b_pipe_pkg::mem_wb_t mem_wb,
	output lc3b_pipe_pkg::id_ex_t  id_ex,
	output logic                   load_use
);

	import lc3b_isa_pkg::*;
	import lc3b_pipe_pkg::*;

	lc3b_word      regs [8];
	control_word_t cw;
	lc3b_reg       sr1_idx;
	lc3b_reg       sr2_idx;
	lc3b_word      src1;
	lc3b_word      src2;
	logic          use_sr1;
	logic          use_sr2;
	logic          wb_en;

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////

	assign wb_en = mem_wb.valid && mem_wb.cw.reg_write;

	always_ff @(posedge clk) begin
		if (wb_en)
			regs[mem_wb.cw.dest] <= mem_wb.result;
	end

	// Write-first read ports.
	assign src1 = (wb_en && mem_wb.cw.dest == sr1_idx) ? mem_wb.result : regs[sr1_idx];
	assign src2 = (wb_en && mem_wb.cw.dest == sr2_idx) ? mem_wb.result : regs[sr2_idx];

	////////////////////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cw        = '0;
		cw.alu_op = alu_pass;
		cw.dest   = get_dr(if_id.ir);
		sr1_idx   = get_sr1(if_id.ir);
		sr2_idx   = get_sr2(if_id.ir);
		use_sr1   = 1'b0;
		use_sr2   = 1'b0;
		case (get_opcode(if_id.ir))
			op_add, op_and: begin
				cw.alu_op    = (get_opcode(if_id.ir) == op_add) ? alu_add : alu_and;
				cw.use_imm   = if_id.ir[5];
				cw.reg_write = 1'b1;
				cw.set_cc    = 1'b1;
				use_sr1      = 1'b1;
				use_sr2      = !if_id.ir[5];
			end
			op_not: begin
				cw.alu_op    = alu_not;
				cw.reg_write = 1'b1;
				cw.set_cc    = 1'b1;
				use_sr1      = 1'b1;
			end
			op_ldr: begin
				cw.alu_op    = alu_add;
				cw.use_imm   = 1'b1;
				cw.mem_read  = 1'b1;
				cw.reg_write = 1'b1;
				use_sr1      = 1'b1;
			end
			op_str: begin
				cw.alu_op    = alu_add;
				cw.use_imm   = 1'b1;
				cw.mem_write = 1'b1;
				sr2_idx      = get_dr(if_id.ir);   // Store data register.
				use_sr1      = 1'b1;
				use_sr2      = 1'b1;
			end
			op_br:   cw.is_branch = 1'b1;
			default: ;
		endcase
	end

	// Load in EX feeding the instruction in ID.
	assign load_use = if_id.valid && id_ex.valid && id_ex.cw.mem_read &&
		((use_sr1 && id_ex.cw.dest == sr1_idx) || (use_sr2 && id_ex.cw.dest == sr2_idx));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (squash || bubble_ex) begin
			id_ex.valid <= 1'b0;
		end else if (en_id) begin
			id_ex.valid   <= if_id.valid;
			id_ex.ir      <= if_id.ir;
			id_ex.pc      <= if_id.pc;
			id_ex.cw      <= cw;
			id_ex.src1    <= src1;
			id_ex.src2    <= src2;
			id_ex.sr1_idx <= sr1_idx;
			id_ex.sr2_idx <= sr2_idx;
		end
	end

endmodule : instruction_decode

`default_nettype wire

// File: design/instruction_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instruction_fetch #(
	parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      en_if,
	input  logic                      squash,
	input  logic                      branch_taken,
	input  lc3b_isa_pkg::lc3b_word    branch_target,
	input  lc3b_pipe_pkg::imem_rsp_t  imem_rsp,
	output lc3b_pipe_pkg::imem_req_t  imem_req,
	output logic                      imem_wait,
	output lc3b_pipe_pkg::if_id_t     if_id
);

	import lc3b_isa_pkg::*;

	lc3b_word pc_q;
	lc3b_word pc_next;
	lc3b_word target_q;   // Redirect held until the stale fetch returns.
	logic     read_q;
	logic     fetch_done;

	assign pc_next    = pc_q + 16'd2;
	assign fetch_done = read_q && imem_rsp.resp;
	assign imem_wait  = read_q && !imem_rsp.resp;
	assign imem_req   = '{read: read_q, addr: pc_q};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_q <= 1'b0;
			pc_q   <= RESET_PC;
		end else begin
			read_q <= 1'b1;
			if (squash && branch_taken) begin
				if (!imem_wait)
					pc_q <= branch_target;
			end else if (squash) begin
				if (!imem_wait)
					pc_q <= target_q;      // Stale fetch done, now redirect.
			end else if (en_if && fetch_done) begin
				pc_q <= pc_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (squash && branch_taken && imem_wait)
			target_q <= branch_target;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (squash) begin
			if_id.valid <= 1'b0;
		end else if (en_if) begin
			if_id.valid <= fetch_done;     // NOP while the memory waits.
			if_id.ir    <= imem_rsp.rdata;
			if_id.pc    <= pc_next;
		end
	end

endmodule : instruction_fetch

`default_nettype wire

// File: design/lc3b_pipe_pkg.sv
`default_nettype none

package lc3b_pipe_pkg;

	import lc3b_isa_pkg::*;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    set_cc;
		logic    is_branch;
		lc3b_reg dest;
	} control_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic     valid;
		lc3b_word ir;
		lc3b_word pc;         // Already incremented.
	} if_id_t;

	typedef struct packed {
		logic          valid;
		lc3b_word      ir;
		lc3b_word      pc;
		control_word_t cw;
		lc3b_word      src1;
		lc3b_word      src2;
		lc3b_reg       sr1_idx;
		lc3b_reg       sr2_idx;
	} id_ex_t;

	typedef struct packed {
		logic          valid;
		control_word_t cw;
		lc3b_word      alu_out;
		lc3b_word      store_data;
	} ex_mem_t;

	typedef struct packed {
		logic          valid;
		control_word_t cw;
		lc3b_word      result;
	} mem_wb_t;

	////////////////////////////////////////////////////////////////////////////
	// Memory ports
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic     read;
		lc3b_word addr;
	} imem_req_t;

	typedef struct packed {
		logic     resp;
		lc3b_word rdata;
	} imem_rsp_t;

	typedef struct packed {
		logic     read;
		logic     write;
		lc3b_word addr;
		lc3b_word wdata;
	} dmem_req_t;

	typedef struct packed {
		logic     resp;
		lc3b_word rdata;
	} dmem_rsp_t;

endpackage : lc3b_pipe_pkg

`default_nettype wire

// File: design/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br    = 4'b0000,
		op_add   = 4'b0001,
		op_and   = 4'b0101,
		op_ldr   = 4'b0110,
		op_str   = 4'b0111,
		op_not   = 4'b1001,
		op_other = 4'b1111
	} lc3b_opcode;

	function automatic lc3b_opcode get_opcode(input lc3b_word ir);
		return lc3b_opcode'(ir[15:12]);
	endfunction

	function automatic lc3b_reg get_dr(input lc3b_word ir);
		return ir[11:9];
	endfunction

	function automatic lc3b_reg get_sr1(input lc3b_word ir);
		return ir[8:6];
	endfunction

	function automatic lc3b_reg get_sr2(input lc3b_word ir);
		return ir[2:0];
	endfunction

	function automatic lc3b_word imm5(input lc3b_word ir);
		return {{11{ir[4]}}, ir[4:0]};
	endfunction

	// Word offsets, already scaled to bytes.
	function automatic lc3b_word offset6(input lc3b_word ir);
		return {{9{ir[5]}}, ir[5:0], 1'b0};
	endfunction

	function automatic lc3b_word offset9(input lc3b_word ir);
		return {{6{ir[8]}}, ir[8:0], 1'b0};
	endfunction

endpackage : lc3b_isa_pkg

`default_nettype wire
